/* filelist.f */
rtl/vga_status_pkg.sv
rtl/buffer_regs_axil.sv
rtl/raster_timing.sv
rtl/buffer_column.sv
rtl/pixel_compose.sv
rtl/vga_status_top.sv
verification/tb_clock_gen.sv
verification/tb_vga_status.sv

/* rtl/buffer_column.sv */
`timescale 1ns/10ps
`default_nettype none

module buffer_column #(
	parameter int COL_IDX = 0
) (
	input  wire logic                              clk,
	input  wire logic                              arst_n_i,
	input  wire logic [vga_status_pkg::CNT_W-1:0]  h_cnt_i,
	input  wire logic [vga_status_pkg::CNT_W-1:0]  v_cnt_i,
	input  wire vga_status_pkg::slot_word_u        word_i,
	output logic                                   hit_o,
	output logic [vga_status_pkg::COLOR_W-1:0]     color_o
);

	import vga_status_pkg::*;

	logic [CNT_W-1:0]   x_off;
	logic [CNT_W-1:0]   y_off;
	logic               in_x;
	logic               in_row;
	logic [2:0]         slot_idx;
	logic [SLOT_W-1:0]  slot;
	logic               on_border;
	logic               hit_d;
	logic [COLOR_W-1:0] color_d;
	logic               hit_q;
	logic [COLOR_W-1:0] color_q;

	assign x_off = h_cnt_i - COL_X[COL_IDX];
	assign in_x  = (h_cnt_i >= COL_X[COL_IDX]) && (x_off < CNT_W'(CELL_SIZE));

	// which of the six cells the line falls in, if any
	always_comb begin
		in_row   = 1'b0;
		slot_idx = '0;
		y_off    = '0;
		for (int s = 0; s < NUM_SLOTS; s++) begin
			if ((v_cnt_i >= CNT_W'(ROW_Y0 + s * ROW_PITCH)) &&
					(v_cnt_i < CNT_W'(ROW_Y0 + s * ROW_PITCH + CELL_SIZE))) begin
				in_row   = 1'b1;
				slot_idx = 3'(s);
				y_off    = v_cnt_i - CNT_W'(ROW_Y0 + s * ROW_PITCH);
			end
		end
	end

	assign slot = word_i.slots[slot_idx];

	// outermost pixel ring of the cell
	assign on_border = (x_off == '0) || (x_off == CNT_W'(CELL_SIZE - 1)) ||
			(y_off == '0) || (y_off == CNT_W'(CELL_SIZE - 1));

	assign hit_d = in_x && in_row;

	always_comb begin
		if (slot[0]) begin
			color_d = CELL_PALETTE[COL_IDX][slot[SLOT_W-1:1]];
		end else if (on_border) begin
			color_d = OUTLINE_COLOR;
		end else begin
			color_d = '0;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			hit_q <= 1'b0;
		end else begin
			hit_q <= hit_d;
		end
	end

	always_ff @(posedge clk) begin
		color_q <= color_d;
	end

	assign hit_o   = hit_q;
	assign color_o = color_q;

endmodule

`default_nettype wire

/* rtl/buffer_regs_axil.sv */
`timescale 1ns/10ps
`default_nettype none

module buffer_regs_axil (
	input  wire logic                                  clk,
	input  wire logic                                  arst_n_i,
	input  wire logic                                  awvalid_i,
	input  wire logic [vga_status_pkg::AXI_ADDR_W-1:0] awaddr_i,
	output logic                                       awready_o,
	input  wire logic                                  wvalid_i,
	input  wire logic [vga_status_pkg::AXI_DATA_W-1:0] wdata_i,
	input  wire logic [3:0]                            wstrb_i,
	output logic                                       wready_o,
	output logic                                       bvalid_o,
	output logic [1:0]                                 bresp_o,
	input  wire logic                                  bready_i,
	input  wire logic                                  arvalid_i,
	input  wire logic [vga_status_pkg::AXI_ADDR_W-1:0] araddr_i,
	output logic                                       arready_o,
	output logic                                       rvalid_o,
	output logic [vga_status_pkg::AXI_DATA_W-1:0]      rdata_o,
	output logic [1:0]                                 rresp_o,
	input  wire logic                                  rready_i,
	output vga_status_pkg::slot_word_u                 buf_words_o [vga_status_pkg::NUM_COLS]
);

	import vga_status_pkg::*;

	logic                    alive_q;
	logic                    bvalid_q;
	logic                    rvalid_q;
	logic [1:0]              bresp_q;
	logic [1:0]              rresp_q;
	logic [AXI_DATA_W-1:0]   rdata_q;
	slot_word_u              words_q [NUM_COLS];
	logic                    wr_fire;
	logic                    rd_fire;
	logic                    wr_ok;
	logic                    rd_ok;
	logic [AXI_ADDR_W-3:0]   wr_idx;
	logic [AXI_ADDR_W-3:0]   rd_idx;

	// address and data are taken together, only while no B is waiting
	assign awready_o = alive_q & awvalid_i & wvalid_i & ~bvalid_q;
	assign wready_o  = awready_o;
	assign arready_o = alive_q & ~rvalid_q;

	assign wr_fire = awready_o;
	assign rd_fire = arvalid_i & arready_o;

	// word aligned offsets 0x0..0xC map onto the four buffers
	assign wr_ok  = (awaddr_i[1:0] == 2'b00);
	assign rd_ok  = (araddr_i[1:0] == 2'b00);
	assign wr_idx = awaddr_i[AXI_ADDR_W-1:2];
	assign rd_idx = araddr_i[AXI_ADDR_W-1:2];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			alive_q  <= 1'b0;
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
			for (int i = 0; i < NUM_COLS; i++) begin
				words_q[i] <= '0;
			end
		end else begin
			alive_q <= 1'b1;

			if (wr_fire) begin
				bvalid_q <= 1'b1;
			end else if (bready_i) begin
				bvalid_q <= 1'b0;
			end

			if (rd_fire) begin
				rvalid_q <= 1'b1;
			end else if (rready_i) begin
				rvalid_q <= 1'b0;
			end

			// strobes ignored, the whole word is replaced
			if (wr_fire && wr_ok) begin
				words_q[wr_idx].raw <= wdata_i[WORD_W-1:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_fire) begin
			bresp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
		end
		if (rd_fire) begin
			rresp_q <= rd_ok ? RESP_OKAY : RESP_SLVERR;
			rdata_q <= rd_ok ? AXI_DATA_W'(words_q[rd_idx].raw) : '0;
		end
	end

	assign bvalid_o    = bvalid_q;
	assign bresp_o     = bresp_q;
	assign rvalid_o    = rvalid_q;
	assign rresp_o     = rresp_q;
	assign rdata_o     = rdata_q;
	assign buf_words_o = words_q;

	// responses wait for the manager
	a_b_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
		bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));

	a_r_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
		rvalid_o && !rready_i |=> rvalid_o && $stable(rresp_o) && $stable(rdata_o));

endmodule

`default_nettype wire

/* rtl/pixel_compose.sv */
`timescale 1ns/10ps
`default_nettype none

module pixel_compose (
	input  wire logic                                 clk,
	input  wire logic                                 arst_n_i,
	input  wire logic [vga_status_pkg::CNT_W-1:0]     h_cnt_i,
	input  wire logic [vga_status_pkg::CNT_W-1:0]     v_cnt_i,
	input  wire logic [vga_status_pkg::NUM_COLS-1:0]  col_hit_i,
	input  wire logic [vga_status_pkg::COLOR_W-1:0]   col_color_i [vga_status_pkg::NUM_COLS],
	output logic                                      vga_hsync_o,
	output logic                                      vga_vsync_o,
	output logic [vga_status_pkg::COLOR_W-1:0]        vga_color_o
);

	import vga_status_pkg::*;

	logic               hsync_d;
	logic               vsync_d;
	logic               active_d;
	logic               hsync_q;
	logic               vsync_q;
	logic               active_q;
	logic [COLOR_W-1:0] sel_color;
	logic [COLOR_W-1:0] pix_color;

	assign hsync_d  = (h_cnt_i < CNT_W'(H_SYNC_LEN));
	assign vsync_d  = (v_cnt_i < CNT_W'(V_SYNC_LEN));
	assign active_d = (h_cnt_i >= CNT_W'(H_ACTIVE_START)) && (h_cnt_i < CNT_W'(H_ACTIVE_END)) &&
			(v_cnt_i >= CNT_W'(V_ACTIVE_START)) && (v_cnt_i < CNT_W'(V_ACTIVE_END));

	// columns never overlap, so an or of the hitting ones is enough
	always_comb begin
		sel_color = '0;
		for (int c = 0; c < NUM_COLS; c++) begin
			if (col_hit_i[c]) begin
				sel_color = sel_color | col_color_i[c];
			end
		end
	end

	assign pix_color = active_q ? sel_color : '0;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			hsync_q     <= 1'b0;
			vsync_q     <= 1'b0;
			active_q    <= 1'b0;
			vga_hsync_o <= 1'b0;
			vga_vsync_o <= 1'b0;
			vga_color_o <= '0;
		end else begin
			// stage 1 lines up with the column registers
			hsync_q     <= hsync_d;
			vsync_q     <= vsync_d;
			active_q    <= active_d;
			vga_hsync_o <= hsync_q;
			vga_vsync_o <= vsync_q;
			vga_color_o <= pix_color;
		end
	end

	a_cols_disjoint: assert property (@(posedge clk) disable iff (!arst_n_i)
		$onehot0(col_hit_i));

endmodule

`default_nettype wire

/* rtl/raster_timing.sv */
`timescale 1ns/10ps
`default_nettype none

module raster_timing (
	input  wire logic                             clk,
	input  wire logic                             arst_n_i,
	output logic [vga_status_pkg::CNT_W-1:0]      h_cnt_o,
	output logic [vga_status_pkg::CNT_W-1:0]      v_cnt_o
);

	import vga_status_pkg::*;

	logic [CNT_W-1:0] h_cnt_q;
	logic [CNT_W-1:0] v_cnt_q;
	logic             line_end;
	logic             frame_end;

	assign line_end  = (h_cnt_q == CNT_W'(H_TOTAL - 1));
	assign frame_end = (v_cnt_q == CNT_W'(V_TOTAL - 1));

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			h_cnt_q <= '0;
			v_cnt_q <= '0;
		end else begin
			if (line_end) begin
				h_cnt_q <= '0;
				// vertical steps once per line
				if (frame_end) begin
					v_cnt_q <= '0;
				end else begin
					v_cnt_q <= v_cnt_q + 1'b1;
				end
			end else begin
				h_cnt_q <= h_cnt_q + 1'b1;
			end
		end
	end

	assign h_cnt_o = h_cnt_q;
	assign v_cnt_o = v_cnt_q;

	a_cnt_range: assert property (@(posedge clk) disable iff (!arst_n_i)
		(h_cnt_o < CNT_W'(H_TOTAL)) && (v_cnt_o < CNT_W'(V_TOTAL)));

endmodule

`default_nettype wire

/* rtl/vga_status_pkg.sv */
`default_nettype none

package vga_status_pkg;

	// 640x480 raster, counted from the start of hsync
	localparam int H_TOTAL        = 800;
	localparam int H_SYNC_LEN     = 96;
	localparam int H_ACTIVE_START = 144;
	localparam int H_ACTIVE_END   = 784;

	localparam int V_TOTAL        = 525;
	localparam int V_SYNC_LEN     = 2;
	localparam int V_ACTIVE_START = 35;
	localparam int V_ACTIVE_END   = 515;

	localparam int CNT_W     = 10;
	localparam int NUM_COLS  = 4;
	localparam int NUM_SLOTS = 6;
	localparam int CELL_SIZE = 36;
	localparam int ROW_Y0    = 120;
	localparam int ROW_PITCH = 45;

	// left edge of each buffer column
	localparam logic [0:NUM_COLS-1][CNT_W-1:0] COL_X = '{10'd200, 10'd255, 10'd315, 10'd375};

	// rgb332
	localparam int COLOR_W = 8;

	// column, then tag
	localparam logic [0:NUM_COLS-1][0:3][COLOR_W-1:0] CELL_PALETTE = '{
		'{8'hE0, 8'hC0, 8'hA0, 8'h80},
		'{8'h03, 8'h02, 8'h01, 8'h4B},
		'{8'hFC, 8'hDC, 8'hB8, 8'h90},
		'{8'h1C, 8'h18, 8'h10, 8'h0C}
	};
	localparam logic [COLOR_W-1:0] OUTLINE_COLOR = 8'h92;

	localparam int SLOT_W = 3;
	localparam int WORD_W = 18;

	// slot 0 sits in the top bits; each slot is {tag[1:0], valid}
	typedef union packed {
		logic [WORD_W-1:0] raw;
		logic [0:NUM_SLOTS-1][SLOT_W-1:0] slots;
	} slot_word_u;

	localparam int AXI_ADDR_W = 4;
	localparam int AXI_DATA_W = 32;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

/* rtl/vga_status_top.sv */
`timescale 1ns/10ps
`default_nettype none

module vga_status_top (
	input  wire logic                                  clk,
	input  wire logic                                  arst_n_i,
	input  wire logic                                  awvalid_i,
	input  wire logic [vga_status_pkg::AXI_ADDR_W-1:0] awaddr_i,
	output logic                                       awready_o,
	input  wire logic                                  wvalid_i,
	input  wire logic [vga_status_pkg::AXI_DATA_W-1:0] wdata_i,
	input  wire logic [3:0]                            wstrb_i,
	output logic                                       wready_o,
	output logic                                       bvalid_o,
	output logic [1:0]                                 bresp_o,
	input  wire logic                                  bready_i,
	input  wire logic                                  arvalid_i,
	input  wire logic [vga_status_pkg::AXI_ADDR_W-1:0] araddr_i,
	output logic                                       arready_o,
	output logic                                       rvalid_o,
	output logic [vga_status_pkg::AXI_DATA_W-1:0]      rdata_o,
	output logic [1:0]                                 rresp_o,
	input  wire logic                                  rready_i,
	output logic                                       vga_hsync_o,
	output logic                                       vga_vsync_o,
	output logic [vga_status_pkg::COLOR_W-1:0]         vga_color_o
);

	import vga_status_pkg::*;

	slot_word_u         buf_words [NUM_COLS];
	logic [CNT_W-1:0]   h_cnt;
	logic [CNT_W-1:0]   v_cnt;
	logic [NUM_COLS-1:0] col_hit;
	logic [COLOR_W-1:0] col_color [NUM_COLS];

	buffer_regs_axil u_regs (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.awvalid_i   (awvalid_i),
		.awaddr_i    (awaddr_i),
		.awready_o   (awready_o),
		.wvalid_i    (wvalid_i),
		.wdata_i     (wdata_i),
		.wstrb_i     (wstrb_i),
		.wready_o    (wready_o),
		.bvalid_o    (bvalid_o),
		.bresp_o     (bresp_o),
		.bready_i    (bready_i),
		.arvalid_i   (arvalid_i),
		.araddr_i    (araddr_i),
		.arready_o   (arready_o),
		.rvalid_o    (rvalid_o),
		.rdata_o     (rdata_o),
		.rresp_o     (rresp_o),
		.rready_i    (rready_i),
		.buf_words_o (buf_words)
	);

	raster_timing u_timing (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.h_cnt_o  (h_cnt),
		.v_cnt_o  (v_cnt)
	);

	// one column per buffer, each with its own colour family
	for (genvar g = 0; g < NUM_COLS; g++) begin : g_col
		buffer_column #(
			.COL_IDX (g)
		) u_col (
			.clk      (clk),
			.arst_n_i (arst_n_i),
			.h_cnt_i  (h_cnt),
			.v_cnt_i  (v_cnt),
			.word_i   (buf_words[g]),
			.hit_o    (col_hit[g]),
			.color_o  (col_color[g])
		);
	end

	pixel_compose u_compose (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.h_cnt_i     (h_cnt),
		.v_cnt_i     (v_cnt),
		.col_hit_i   (col_hit),
		.col_color_i (col_color),
		.vga_hsync_o (vga_hsync_o),
		.vga_vsync_o (vga_vsync_o),
		.vga_color_o (vga_color_o)
	);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	-f filelist.f \
	--top-module tb_vga_status \
	-Mdir obj_dir -o sim_vga_status

./obj_dir/sim_vga_status | tee sim.log

if grep -q "NO ERRORS" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

/* verification/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 5,
	parameter int DRIVE_DELAY  = 2
) (
	output logic clk_o,
	output logic arst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clk_o = ~clk_o;
		end
	end

	// released just after an edge, like every other input
	initial begin
		arst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		#DRIVE_DELAY;
		arst_n_o = 1'b1;
	end

endmodule

`default_nettype wire

/* verification/tb_vga_status.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_vga_status;

	import vga_status_pkg::*;

	localparam int     DRIVE_DELAY     = 2;
	localparam int     HANDSHAKE_LIMIT = 64;
	localparam int     FRAME_CYCLES    = H_TOTAL * V_TOTAL;
	// six frames of 420000 cycles at 40 ns plus a tenth
	localparam longint WATCHDOG_NS     = 64'd6 * 64'd420000 * 64'd40 * 64'd11 / 64'd10;

	logic                  clk;
	logic                  arst_n;
	logic                  awvalid;
	logic [AXI_ADDR_W-1:0] awaddr;
	logic                  awready;
	logic                  wvalid;
	logic [AXI_DATA_W-1:0] wdata;
	logic [3:0]            wstrb;
	logic                  wready;
	logic                  bvalid;
	logic [1:0]            bresp;
	logic                  bready;
	logic                  arvalid;
	logic [AXI_ADDR_W-1:0] araddr;
	logic                  arready;
	logic                  rvalid;
	logic [AXI_DATA_W-1:0] rdata;
	logic [1:0]            rresp;
	logic                  rready;
	logic                  vga_hsync;
	logic                  vga_vsync;
	logic [COLOR_W-1:0]    vga_color;

	slot_word_u            model_words [NUM_COLS];
	logic [19:0]           lfsr_q = 20'd75502;
	bit                    synced = 1'b0;
	int                    ref_h = 0;
	int                    ref_v = 0;

	tb_clock_gen #(
		.PERIOD_NS    (40),
		.RESET_CYCLES (5),
		.DRIVE_DELAY  (DRIVE_DELAY)
	) clk_gen_i (
		.clk_o    (clk),
		.arst_n_o (arst_n)
	);

	vga_status_top dut_i (
		.clk         (clk),
		.arst_n_i    (arst_n),
		.awvalid_i   (awvalid),
		.awaddr_i    (awaddr),
		.awready_o   (awready),
		.wvalid_i    (wvalid),
		.wdata_i     (wdata),
		.wstrb_i     (wstrb),
		.wready_o    (wready),
		.bvalid_o    (bvalid),
		.bresp_o     (bresp),
		.bready_i    (bready),
		.arvalid_i   (arvalid),
		.araddr_i    (araddr),
		.arready_o   (arready),
		.rvalid_o    (rvalid),
		.rdata_o     (rdata),
		.rresp_o     (rresp),
		.rready_i    (rready),
		.vga_hsync_o (vga_hsync),
		.vga_vsync_o (vga_vsync),
		.vga_color_o (vga_color)
	);

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	// x^20 + x^17 + 1 with one step per bit
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] bits;
		logic        fb;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			fb     = lfsr_q[19] ^ lfsr_q[16];
			bits   = {bits[30:0], lfsr_q[19]};
			lfsr_q = {lfsr_q[18:0], fb};
		end
		return bits;
	endfunction

	task automatic check_bit(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			abort_run($sformatf("[ERROR] %0t: %s expected %b got %b (raster %0d,%0d)",
				$time, what, expected, actual, ref_h, ref_v));
		end
	endtask

	task automatic check_color(input logic [COLOR_W-1:0] actual, input logic [COLOR_W-1:0] expected);
		if (actual !== expected) begin
			abort_run($sformatf("[ERROR] %0t: colour at (%0d,%0d) expected %02h got %02h",
				$time, ref_h, ref_v, expected, actual));
		end
	endtask

	task automatic check_resp(input logic [1:0] actual, input logic [1:0] expected, input string what);
		if (actual !== expected) begin
			abort_run($sformatf("[ERROR] %0t: %s expected %b got %b", $time, what, expected, actual));
		end
	endtask

	task automatic check_word(input slot_word_u actual, input slot_word_u expected, input string what);
		if (actual.raw !== expected.raw) begin
			abort_run($sformatf("[ERROR] %0t: %s expected %05h got %05h",
				$time, what, expected.raw, actual.raw));
		end
	endtask

	// advance one clock and step the raster model with the DUT output position
	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
		if (synced) begin
			if (ref_h == H_TOTAL - 1) begin
				ref_h = 0;
				ref_v = (ref_v == V_TOTAL - 1) ? 0 : ref_v + 1;
			end else begin
				ref_h = ref_h + 1;
			end
		end
	endtask

	function automatic logic [COLOR_W-1:0] expected_pixel(input int h, input int v);
		logic [COLOR_W-1:0] px;
		logic [SLOT_W-1:0]  slot;
		int                 x0;
		int                 y0;
		px = '0;
		if (h < H_ACTIVE_START || h >= H_ACTIVE_END || v < V_ACTIVE_START || v >= V_ACTIVE_END) begin
			return px;
		end
		for (int c = 0; c < NUM_COLS; c++) begin
			for (int s = 0; s < NUM_SLOTS; s++) begin
				x0 = int'(COL_X[c]);
				y0 = ROW_Y0 + s * ROW_PITCH;
				if (h >= x0 && h < x0 + CELL_SIZE && v >= y0 && v < y0 + CELL_SIZE) begin
					slot = model_words[c].raw[WORD_W-1-SLOT_W*s -: SLOT_W];
					if (slot[0]) begin
						px = CELL_PALETTE[c][slot[2:1]];
					end else if (h == x0 || h == x0 + CELL_SIZE - 1 ||
							v == y0 || v == y0 + CELL_SIZE - 1) begin
						px = OUTLINE_COLOR;
					end
				end
			end
		end
		return px;
	endfunction

	task automatic axil_write(input logic [AXI_ADDR_W-1:0] addr, input logic [AXI_DATA_W-1:0] data,
			input int hold, output logic [1:0] resp);
		int         n;
		logic [1:0] first;
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		// ready follows the valids within the cycle
		#1;
		check_bit(awready, 1'b1, "awready with address and data valid");
		check_bit(wready, 1'b1, "wready with address and data valid");
		next_cycle();
		n = 1;
		while (!bvalid) begin
			if (n >= HANDSHAKE_LIMIT) begin
				abort_run("write was never answered by the DUT");
			end
			next_cycle();
			n++;
		end
		check_bit(awready, 1'b0, "awready with B pending");
		check_bit(wready, 1'b0, "wready with B pending");
		awvalid = 1'b0;
		wvalid  = 1'b0;
		first   = bresp;
		repeat (hold) begin
			next_cycle();
			check_bit(bvalid, 1'b1, "bvalid under back-pressure");
			check_resp(bresp, first, "bresp under back-pressure");
		end
		bready = 1'b1;
		next_cycle();
		bready = 1'b0;
		check_bit(bvalid, 1'b0, "bvalid after handshake");
		resp = first;
	endtask

	task automatic axil_read(input logic [AXI_ADDR_W-1:0] addr, input int hold,
			output logic [AXI_DATA_W-1:0] data, output logic [1:0] resp);
		int                    n;
		logic [1:0]            first_resp;
		logic [AXI_DATA_W-1:0] first_data;
		araddr  = addr;
		arvalid = 1'b1;
		#1;
		check_bit(arready, 1'b1, "arready with no read pending");
		next_cycle();
		n = 1;
		while (!rvalid) begin
			if (n >= HANDSHAKE_LIMIT) begin
				abort_run("read was never answered by the DUT");
			end
			next_cycle();
			n++;
		end
		check_bit(arready, 1'b0, "arready with R pending");
		arvalid    = 1'b0;
		first_resp = rresp;
		first_data = rdata;
		repeat (hold) begin
			next_cycle();
			check_bit(rvalid, 1'b1, "rvalid under back-pressure");
			check_resp(rresp, first_resp, "rresp under back-pressure");
			check_bit(rdata == first_data, 1'b1, "rdata stable under back-pressure");
		end
		rready = 1'b1;
		next_cycle();
		rready = 1'b0;
		check_bit(rvalid, 1'b0, "rvalid after handshake");
		data = first_data;
		resp = first_resp;
	endtask

	// upper data bits set to show that they are dropped
	task automatic write_word(input int idx, input slot_word_u w);
		logic [1:0] resp;
		axil_write(AXI_ADDR_W'(4 * idx), {{(AXI_DATA_W - WORD_W){1'b1}}, w.raw}, 0, resp);
		check_resp(resp, RESP_OKAY, "write response");
		model_words[idx] = w;
	endtask

	task automatic readback_all();
		logic [AXI_DATA_W-1:0] data;
		logic [1:0]            resp;
		slot_word_u            got;
		for (int i = 0; i < NUM_COLS; i++) begin
			axil_read(AXI_ADDR_W'(4 * i), 0, data, resp);
			check_resp(resp, RESP_OKAY, "read response");
			got.raw = data[WORD_W-1:0];
			check_word(got, model_words[i], "read back word");
			check_bit(|data[AXI_DATA_W-1:WORD_W], 1'b0, "zero extension of read data");
		end
	endtask

	task automatic scan_frame();
		repeat (2) next_cycle();
		repeat (FRAME_CYCLES) begin
			next_cycle();
			check_bit(vga_hsync, ref_h < H_SYNC_LEN, "hsync");
			check_bit(vga_vsync, ref_v < V_SYNC_LEN, "vsync");
			check_color(vga_color, expected_pixel(ref_h, ref_v));
		end
	endtask

	task automatic check_idle(input logic with_ready);
		check_bit(bvalid, 1'b0, "bvalid in reset");
		check_bit(rvalid, 1'b0, "rvalid in reset");
		check_bit(vga_hsync, 1'b0, "hsync in reset");
		check_bit(vga_vsync, 1'b0, "vsync in reset");
		check_color(vga_color, '0);
		if (with_ready) begin
			check_bit(awready, 1'b0, "awready in reset");
			check_bit(wready, 1'b0, "wready in reset");
			check_bit(arready, 1'b0, "arready in reset");
		end
	endtask

	task automatic test_reset();
		repeat (4) begin
			next_cycle();
			check_idle(1'b1);
		end
		@(posedge arst_n);
		#1;
		check_idle(1'b1);
		next_cycle();
		check_idle(1'b0);
		// position (0,0) reaches the pins two edges after release
		next_cycle();
		check_bit(vga_hsync, 1'b1, "first hsync rise");
		check_bit(vga_vsync, 1'b1, "first vsync rise");
		synced = 1'b1;
		ref_h  = 0;
		ref_v  = 0;
		check_color(vga_color, expected_pixel(0, 0));
	endtask

	task automatic test_registers();
		slot_word_u            w;
		slot_word_u            got;
		logic [AXI_DATA_W-1:0] data;
		logic [1:0]            resp;
		for (int i = 0; i < NUM_COLS; i++) begin
			w.raw = WORD_W'(lfsr_bits(WORD_W));
			write_word(i, w);
		end
		readback_all();
		// misaligned offset lies outside the map
		axil_write(4'h6, '1, 0, resp);
		check_resp(resp, RESP_SLVERR, "bad address write");
		axil_read(4'h6, 0, data, resp);
		check_resp(resp, RESP_SLVERR, "bad address read");
		check_bit(|data, 1'b0, "read data for bad address");
		readback_all();
		w.raw = WORD_W'(lfsr_bits(WORD_W));
		axil_write(4'h8, AXI_DATA_W'(w.raw), 6, resp);
		check_resp(resp, RESP_OKAY, "held write response");
		model_words[2] = w;
		axil_read(4'h8, 6, data, resp);
		check_resp(resp, RESP_OKAY, "held read response");
		got.raw = data[WORD_W-1:0];
		check_word(got, w, "held read word");
	endtask

	task automatic test_filled_cells();
		slot_word_u w;
		for (int c = 0; c < NUM_COLS; c++) begin
			w.raw = '0;
			for (int s = 0; s < NUM_SLOTS; s++) begin
				w.raw[WORD_W-1-SLOT_W*s -: SLOT_W] = {2'((s + c) % 4), 1'b1};
			end
			write_word(c, w);
		end
		scan_frame();
	endtask

	task automatic test_empty_cells();
		slot_word_u           w;
		logic [NUM_SLOTS-1:0] clear;
		for (int c = 0; c < NUM_COLS; c++) begin
			w     = model_words[c];
			clear = NUM_SLOTS'(lfsr_bits(NUM_SLOTS));
			if (clear == '0) begin
				clear[c] = 1'b1;
			end
			for (int s = 0; s < NUM_SLOTS; s++) begin
				if (clear[s]) begin
					w.raw[WORD_W-SLOT_W-SLOT_W*s] = 1'b0;
				end
			end
			write_word(c, w);
		end
		scan_frame();
	endtask

	initial begin
		#(WATCHDOG_NS);
		abort_run($sformatf("timeout: tests still running after %0d ns", WATCHDOG_NS));
	end

	initial begin
		awvalid = 1'b0;
		awaddr  = '0;
		wvalid  = 1'b0;
		wdata   = '0;
		wstrb   = '1;
		bready  = 1'b0;
		arvalid = 1'b0;
		araddr  = '0;
		rready  = 1'b0;
		for (int i = 0; i < NUM_COLS; i++) begin
			model_words[i].raw = '0;
		end
		test_reset();
		test_registers();
		scan_frame();
		test_filled_cells();
		test_empty_cells();
		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire
